//--- build.f
hdl/roce_tx_pkg.sv
hdl/frame_beat_if.sv
hdl/ipv4_header_gen.sv
hdl/frame_assembler.sv
hdl/frame_fifo.sv
hdl/roce_tx_top.sv
test/roce_tx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the RoCEv2 transmit framer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=roce_tx_sim

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module roce_tx_tb \
  -Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- test/roce_tx_tb.sv
`timescale 1ns/1ns

module roce_tx_tb;

  localparam int FRAMES         = 40;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = FRAMES * (4 * 34 + 40) + RESET_CYCLES;

  logic                       clk;
  logic                       rst_n;
  logic                       desc_valid;
  logic                       desc_ready;
  roce_tx_pkg::len_t          desc_len;
  roce_tx_pkg::mac_t          desc_smac;
  roce_tx_pkg::mac_t          desc_dmac;
  roce_tx_pkg::ip_t           desc_sip;
  roce_tx_pkg::ip_t           desc_dip;
  logic                       payload_empty;
  roce_tx_pkg::data_t         payload_data;
  logic                       payload_rd;
  logic                       tx_valid;
  logic                       tx_ready;
  roce_tx_pkg::data_t         tx_data;
  roce_tx_pkg::keep_t         tx_keep;
  logic                       tx_last;

  // frame table
  int                         lens [FRAMES];
  roce_tx_pkg::mac_t          smacs [FRAMES];
  roce_tx_pkg::mac_t          dmacs [FRAMES];
  roce_tx_pkg::ip_t           sips [FRAMES];
  roce_tx_pkg::ip_t           dips [FRAMES];
  int                         start_word [FRAMES];
  int                         pops [FRAMES];
  int                         total_words;

  logic [15:0]                lfsr_q;
  logic                       desc_en = 1'b0;
  int                         cycle_cnt = 0;
  int                         d_idx = 0;
  int                         rd_word = 0;
  int                         out_idx = 0;
  int                         beat_cnt = 0;
  int                         beats_seen = 0;
  logic [7:0]                 exp_hdr [42];

  // previous cycle of the tx port
  logic                       hold_valid = 1'b0;
  logic                       hold_ready = 1'b0;
  roce_tx_pkg::data_t         hold_data;
  roce_tx_pkg::keep_t         hold_keep;
  logic                       hold_last;

  int err_reset = 0;
  int err_header = 0;
  int err_payload = 0;
  int err_stable = 0;
  int err_reads = 0;
  int err_desc = 0;
  int err_total;
  logic timed_out = 1'b0;

  roce_tx_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .desc_valid    (desc_valid),
    .desc_ready    (desc_ready),
    .desc_len      (desc_len),
    .desc_smac     (desc_smac),
    .desc_dmac     (desc_dmac),
    .desc_sip      (desc_sip),
    .desc_dip      (desc_dip),
    .payload_empty (payload_empty),
    .payload_data  (payload_data),
    .payload_rd    (payload_rd),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .tx_data       (tx_data),
    .tx_keep       (tx_keep),
    .tx_last       (tx_last)
  );

  always #4 clk = ~clk;

  // **************************************************
  // random source with taps x^16 + x^14 + x^13 + x^11
  // **************************************************
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // counter pattern for word g of the payload stream
  function automatic roce_tx_pkg::data_t word_value(input int g);
    roce_tx_pkg::data_t w;
    for (int b = 0; b < 32; b++) begin
      w[8*b +: 8] = 8'(g * 37 + b);
    end
    return w;
  endfunction

  function automatic logic [7:0] payload_byte(input int f, input int j);
    return 8'((start_word[f] + j / 32) * 37 + j % 32);
  endfunction

  function automatic string field_name(input int k);
    if (k < 6) return "dmac";
    if (k < 12) return "smac";
    if (k < 14) return "ethertype";
    if (k < 16) return "version_tos";
    if (k < 18) return "total_length";
    if (k < 20) return "identification";
    if (k < 22) return "flags_offset";
    if (k < 24) return "ttl_protocol";
    if (k < 26) return "ip_checksum";
    if (k < 30) return "sip";
    if (k < 34) return "dip";
    if (k < 38) return "udp_ports";
    if (k < 40) return "udp_length";
    return "udp_checksum";
  endfunction

  task automatic make_descriptors();
    int forced [6];
    forced = '{1, 22, 23, 32, 64, 1024};
    total_words = 0;
    for (int f = 0; f < FRAMES; f++) begin
      if (f < 6) begin
        lens[f] = forced[f];
      end else begin
        lens[f] = int'(rand_bits(10)) + 1;
      end
      dmacs[f][47:32] = 16'(rand_bits(16));
      dmacs[f][31:0]  = rand_bits(32);
      smacs[f][47:32] = 16'(rand_bits(16));
      smacs[f][31:0]  = rand_bits(32);
      sips[f]         = rand_bits(32);
      dips[f]         = rand_bits(32);
      start_word[f]   = total_words;
      pops[f]         = 0;
      total_words     = total_words + (lens[f] + 31) / 32;
    end
  endtask

  // expected header with the checksum over the ten IPv4 words
  task automatic build_header(input int f);
    logic [42*8-1:0] msb;
    logic [15:0]     tl;
    logic [15:0]     ul;
    logic [15:0]     id;
    logic [31:0]     sum;
    logic [15:0]     csum;
    tl  = 16'(lens[f] + 28);
    ul  = 16'(lens[f] + 8);
    id  = 16'(f);
    sum = 32'h4500 + 32'(tl) + 32'(id) + 32'h4011;
    sum = sum + 32'(sips[f][31:16]) + 32'(sips[f][15:0]);
    sum = sum + 32'(dips[f][31:16]) + 32'(dips[f][15:0]);
    while (sum > 32'hFFFF) begin
      sum = (sum & 32'hFFFF) + (sum >> 16);
    end
    csum = ~sum[15:0];
    msb = {dmacs[f], smacs[f], 16'h0800, 8'h45, 8'h00, tl, id, 16'h0000,
           8'd64, 8'd17, csum, sips[f], dips[f], 16'd4791, 16'd4791, ul, 16'h0000};
    for (int k = 0; k < 42; k++) begin
      exp_hdr[k] = msb[8*(41-k) +: 8];
    end
  endtask

  task automatic check_beat();
    int                 flen;
    int                 nbeats;
    int                 k;
    logic [7:0]         got;
    logic [7:0]         exp;
    roce_tx_pkg::keep_t exp_keep;
    flen   = 42 + lens[out_idx];
    nbeats = (flen + 31) / 32;
    if (beat_cnt == 0) begin
      build_header(out_idx);
    end
    for (int b = 0; b < 32; b++) begin
      k = beat_cnt * 32 + b;
      got = tx_data[8*b +: 8];
      exp_keep[b] = (k < flen);
      if (k < 42) begin
        assert (got == exp_hdr[k]) else begin
          $display("[FAIL] tx_data %s (frame %0d byte %0d): expected %h got %h",
                   field_name(k), out_idx, k, exp_hdr[k], got);
          err_header++;
        end
      end else begin
        exp = (k < flen) ? payload_byte(out_idx, k - 42) : 8'h00;
        assert (got == exp) else begin
          $display("[FAIL] tx_data (frame %0d byte %0d): expected %h got %h",
                   out_idx, k, exp, got);
          err_payload++;
        end
      end
    end
    assert (tx_keep == exp_keep) else begin
      $display("[FAIL] tx_keep (frame %0d beat %0d): expected %h got %h",
               out_idx, beat_cnt, exp_keep, tx_keep);
      err_payload++;
    end
    assert (tx_last == (beat_cnt == nbeats - 1)) else begin
      $display("[FAIL] tx_last (frame %0d beat %0d): expected %h got %h",
               out_idx, beat_cnt, (beat_cnt == nbeats - 1), tx_last);
      err_payload++;
    end
    if (beat_cnt == nbeats - 1) begin
      beat_cnt = 0;
      out_idx++;
    end else begin
      beat_cnt++;
    end
  endtask

  // **************************************************
  // stimulus for descriptors, payload source and tx_ready
  // **************************************************
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_n) begin
      if (payload_rd) begin
        if (d_idx > 0) begin
          pops[d_idx-1]++;
        end
        rd_word++;
      end
      if (desc_valid && desc_ready) begin
        d_idx++;
      end
      if (desc_en && d_idx < FRAMES) begin
        desc_valid <= 1'b1;
        desc_len   <= 16'(lens[d_idx]);
        desc_smac  <= smacs[d_idx];
        desc_dmac  <= dmacs[d_idx];
        desc_sip   <= sips[d_idx];
        desc_dip   <= dips[d_idx];
      end else begin
        desc_valid <= 1'b0;
      end
      payload_data  <= word_value(rd_word);
      // gap about one cycle in four
      payload_empty <= (rd_word >= total_words) || (rand_bits(2) == 32'd0);
      tx_ready      <= lfsr_bit();
    end
  end

  // monitor
  always @(posedge clk) begin
    if (!desc_en) begin
      assert (!tx_valid && !payload_rd && desc_ready) else begin
        $display("outputs not idle before the first descriptor at cycle %0d", cycle_cnt);
        err_reset++;
      end
    end
    if (rst_n) begin
      assert (!(payload_rd && payload_empty)) else begin
        $display("payload_rd high while payload_empty high at cycle %0d", cycle_cnt);
        err_reads++;
      end
      if (hold_valid && !hold_ready) begin
        assert (tx_valid && tx_data == hold_data && tx_keep == hold_keep &&
                tx_last == hold_last) else begin
          $display("tx beat changed while tx_ready was low at cycle %0d", cycle_cnt);
          err_stable++;
        end
      end
      hold_valid = tx_valid;
      hold_ready = tx_ready;
      hold_data  = tx_data;
      hold_keep  = tx_keep;
      hold_last  = tx_last;
      if (tx_valid && tx_ready) begin
        beats_seen++;
        if (out_idx < FRAMES) begin
          check_beat();
        end else begin
          $display("unexpected tx beat after the last frame at cycle %0d", cycle_cnt);
          err_desc++;
        end
      end
    end
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    desc_valid    = 1'b0;
    desc_len      = '0;
    desc_smac     = '0;
    desc_dmac     = '0;
    desc_sip      = '0;
    desc_dip      = '0;
    payload_empty = 1'b1;
    payload_data  = '0;
    tx_ready      = 1'b0;
    lfsr_q        = 16'd24432;
    make_descriptors();

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    desc_en <= 1'b1;
    @(posedge clk);
    $display("reset state: %0d errors", err_reset);

    // counters are read between edges, after the monitor has run
    while (out_idx < FRAMES && cycle_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
    end
    if (out_idx < FRAMES) begin
      $display("timeout after %0d cycles, %0d of %0d frames received",
               cycle_cnt, out_idx, FRAMES);
      timed_out = 1'b1;
    end
    repeat (4) @(negedge clk);

    for (int f = 0; f < FRAMES; f++) begin
      assert (pops[f] == (lens[f] + 31) / 32) else begin
        $display("[FAIL] payload_rd pops (frame %0d): expected %h got %h",
                 f, (lens[f] + 31) / 32, pops[f]);
        err_reads++;
      end
    end
    assert (d_idx == FRAMES && out_idx == FRAMES) else begin
      $display("%0d descriptors accepted and %0d frames received, %0d expected",
               d_idx, out_idx, FRAMES);
      err_desc++;
    end

    $display("header content: %0d errors", err_header);
    $display("payload and framing: %0d errors", err_payload);
    $display("back-pressure stability: %0d errors", err_stable);
    $display("payload reads: %0d errors", err_reads);
    $display("descriptor acceptance: %0d errors", err_desc);
    err_total = err_reset + err_header + err_payload + err_stable + err_reads + err_desc;
    $display("totals: %0d frames, %0d beats, %0d errors, %0d cycles",
             out_idx, beats_seen, err_total, cycle_cnt);
    if (err_total == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/roce_tx_top.sv
`timescale 1ns/1ns

module roce_tx_top (
  input  logic               clk,
  input  logic               rst_n,
  // descriptor
  input  logic               desc_valid,
  output logic               desc_ready,
  input  roce_tx_pkg::len_t  desc_len,
  input  roce_tx_pkg::mac_t  desc_smac,
  input  roce_tx_pkg::mac_t  desc_dmac,
  input  roce_tx_pkg::ip_t   desc_sip,
  input  roce_tx_pkg::ip_t   desc_dip,
  // payload source, first word falls through
  input  logic               payload_empty,
  input  roce_tx_pkg::data_t payload_data,
  output logic               payload_rd,
  // frame stream out
  output logic               tx_valid,
  input  logic               tx_ready,
  output roce_tx_pkg::data_t tx_data,
  output roce_tx_pkg::keep_t tx_keep,
  output logic               tx_last
);

  roce_tx_pkg::len_t    hdr_len;
  roce_tx_pkg::mac_t    hdr_smac;
  roce_tx_pkg::mac_t    hdr_dmac;
  roce_tx_pkg::ip_t     hdr_sip;
  roce_tx_pkg::ip_t     hdr_dip;
  logic                 header_taken;
  roce_tx_pkg::header_t header;

  frame_beat_if beat_if ();

  frame_assembler u_assembler (
    .clk           (clk),
    .rst_n         (rst_n),
    .desc_valid    (desc_valid),
    .desc_ready    (desc_ready),
    .desc_len      (desc_len),
    .desc_smac     (desc_smac),
    .desc_dmac     (desc_dmac),
    .desc_sip      (desc_sip),
    .desc_dip      (desc_dip),
    .payload_empty (payload_empty),
    .payload_data  (payload_data),
    .payload_rd    (payload_rd),
    .hdr_len       (hdr_len),
    .hdr_smac      (hdr_smac),
    .hdr_dmac      (hdr_dmac),
    .hdr_sip       (hdr_sip),
    .hdr_dip       (hdr_dip),
    .header_taken  (header_taken),
    .header        (header),
    .beat          (beat_if.assembler)
  );

  ipv4_header_gen u_header_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .hdr_len      (hdr_len),
    .hdr_smac     (hdr_smac),
    .hdr_dmac     (hdr_dmac),
    .hdr_sip      (hdr_sip),
    .hdr_dip      (hdr_dip),
    .header_taken (header_taken),
    .header       (header)
  );

  frame_fifo u_frame_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .beat     (beat_if.fifo),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_data  (tx_data),
    .tx_keep  (tx_keep),
    .tx_last  (tx_last)
  );

endmodule

//--- hdl/frame_fifo.sv
`timescale 1ns/1ns

module frame_fifo (
  input  logic                clk,
  input  logic                rst_n,
  frame_beat_if.fifo          beat,
  output logic                tx_valid,
  input  logic                tx_ready,
  output roce_tx_pkg::data_t  tx_data,
  output roce_tx_pkg::keep_t  tx_keep,
  output logic                tx_last
);

  roce_tx_pkg::data_t     mem_data [roce_tx_pkg::FIFO_DEPTH];
  roce_tx_pkg::keep_t     mem_keep [roce_tx_pkg::FIFO_DEPTH];
  logic                   mem_last [roce_tx_pkg::FIFO_DEPTH];
  roce_tx_pkg::fifo_ptr_t wr_ptr;
  roce_tx_pkg::fifo_ptr_t rd_ptr;
  roce_tx_pkg::fifo_cnt_t count;
  roce_tx_pkg::fifo_cnt_t free_slots;
  logic                   pop;

  assign pop        = tx_valid && tx_ready;
  assign free_slots = roce_tx_pkg::fifo_cnt_t'(roce_tx_pkg::FIFO_DEPTH) - count;

  // keeps room for the beat already being written
  assign beat.almost_full = free_slots < roce_tx_pkg::fifo_cnt_t'(roce_tx_pkg::FIFO_SLACK);

  always_ff @(posedge clk) begin
    if (beat.wr) begin
      mem_data[wr_ptr] <= beat.data;
      mem_keep[wr_ptr] <= beat.keep;
      mem_last[wr_ptr] <= beat.last;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (beat.wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + roce_tx_pkg::fifo_cnt_t'(beat.wr) - roce_tx_pkg::fifo_cnt_t'(pop);
    end
  end

  // head entry holds still until it is taken
  assign tx_valid = (count != '0);
  assign tx_data  = mem_data[rd_ptr];
  assign tx_keep  = mem_keep[rd_ptr];
  assign tx_last  = tx_valid && mem_last[rd_ptr];

endmodule

//--- hdl/frame_assembler.sv
`timescale 1ns/1ns

module frame_assembler (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  desc_valid,
  output logic                  desc_ready,
  input  roce_tx_pkg::len_t     desc_len,
  input  roce_tx_pkg::mac_t     desc_smac,
  input  roce_tx_pkg::mac_t     desc_dmac,
  input  roce_tx_pkg::ip_t      desc_sip,
  input  roce_tx_pkg::ip_t      desc_dip,
  input  logic                  payload_empty,
  input  roce_tx_pkg::data_t    payload_data,
  output logic                  payload_rd,
  output roce_tx_pkg::len_t     hdr_len,
  output roce_tx_pkg::mac_t     hdr_smac,
  output roce_tx_pkg::mac_t     hdr_dmac,
  output roce_tx_pkg::ip_t      hdr_sip,
  output roce_tx_pkg::ip_t      hdr_dip,
  output logic                  header_taken,
  input  roce_tx_pkg::header_t  header,
  frame_beat_if.assembler       beat
);

  localparam int unsigned CARRY_W = 8 * roce_tx_pkg::HDR_CARRY_BYTES;
  localparam int unsigned FRESH_W = 8 * roce_tx_pkg::FRESH_BYTES;

  roce_tx_pkg::asm_state_e state_q;
  roce_tx_pkg::asm_state_e state_d;
  roce_tx_pkg::len_t       rem_q;
  roce_tx_pkg::len_t       rem_d;
  logic [CARRY_W-1:0]      carry_q;
  roce_tx_pkg::data_t      beat_raw;
  roce_tx_pkg::keep_t      beat_keep;

  // low n bytes valid, n of 32 gives all ones
  function automatic roce_tx_pkg::keep_t keep_mask(input logic [5:0] n);
    keep_mask = ~(roce_tx_pkg::keep_t'('1) << n);
  endfunction

  // zero every byte outside keep
  function automatic roce_tx_pkg::data_t data_mask(input roce_tx_pkg::data_t d,
                                                   input roce_tx_pkg::keep_t k);
    for (int i = 0; i < roce_tx_pkg::KEEP_W; i++) begin
      data_mask[8*i +: 8] = d[8*i +: 8] & {8{k[i]}};
    end
  endfunction

  assign desc_ready = (state_q == roce_tx_pkg::ASM_IDLE);

  // **************************************************
  // beat sequencing
  // **************************************************
  always_comb begin
    state_d      = state_q;
    rem_d        = rem_q;
    beat.wr      = 1'b0;
    beat.last    = 1'b0;
    payload_rd   = 1'b0;
    header_taken = 1'b0;
    beat_keep    = '1;
    // carried header or payload bytes first, then fresh payload
    beat_raw     = {payload_data[FRESH_W-1:0], carry_q};
    case (state_q)
      roce_tx_pkg::ASM_IDLE: begin
        if (desc_valid) begin
          state_d = roce_tx_pkg::ASM_HEADER;
        end
      end
      roce_tx_pkg::ASM_HEADER: begin
        if (!beat.almost_full) begin
          beat.wr      = 1'b1;
          header_taken = 1'b1;
          beat_raw     = header[roce_tx_pkg::DATA_W-1:0];
          rem_d        = hdr_len;
          state_d      = roce_tx_pkg::ASM_PAYLOAD;
        end
      end
      roce_tx_pkg::ASM_PAYLOAD: begin
        if (!payload_empty && !beat.almost_full) begin
          beat.wr    = 1'b1;
          payload_rd = 1'b1;
          if (rem_q <= roce_tx_pkg::len_t'(roce_tx_pkg::FRESH_BYTES)) begin
            // everything left fits behind the carry
            beat_keep = keep_mask(6'(rem_q) + 6'(roce_tx_pkg::HDR_CARRY_BYTES));
            beat.last = 1'b1;
            state_d   = roce_tx_pkg::ASM_IDLE;
          end else if (rem_q <= roce_tx_pkg::len_t'(roce_tx_pkg::KEEP_W)) begin
            rem_d   = rem_q - roce_tx_pkg::len_t'(roce_tx_pkg::FRESH_BYTES);
            state_d = roce_tx_pkg::ASM_TAIL;
          end else begin
            rem_d = rem_q - roce_tx_pkg::len_t'(roce_tx_pkg::KEEP_W);
          end
        end
      end
      roce_tx_pkg::ASM_TAIL: begin
        // only the carried bytes remain, rem holds their count
        if (!beat.almost_full) begin
          beat.wr   = 1'b1;
          beat.last = 1'b1;
          beat_raw  = {{FRESH_W{1'b0}}, carry_q};
          beat_keep = keep_mask(6'(rem_q));
          state_d   = roce_tx_pkg::ASM_IDLE;
        end
      end
      default: begin
        state_d = roce_tx_pkg::ASM_IDLE;
      end
    endcase
  end

  assign beat.keep = beat_keep;
  assign beat.data = data_mask(beat_raw, beat_keep);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= roce_tx_pkg::ASM_IDLE;
      rem_q   <= '0;
    end else begin
      state_q <= state_d;
      rem_q   <= rem_d;
    end
  end

  // descriptor fields held for the header generator
  always_ff @(posedge clk) begin
    if (desc_valid && desc_ready) begin
      hdr_len  <= desc_len;
      hdr_smac <= desc_smac;
      hdr_dmac <= desc_dmac;
      hdr_sip  <= desc_sip;
      hdr_dip  <= desc_dip;
    end
  end

  // upper bytes held back for the next beat
  always_ff @(posedge clk) begin
    if (header_taken) begin
      carry_q <= header[roce_tx_pkg::HDR_BYTES*8-1 -: CARRY_W];
    end else if (payload_rd) begin
      carry_q <= payload_data[roce_tx_pkg::DATA_W-1 -: CARRY_W];
    end
  end

endmodule

//--- hdl/ipv4_header_gen.sv
`timescale 1ns/1ns

module ipv4_header_gen (
  input  logic                  clk,
  input  logic                  rst_n,
  input  roce_tx_pkg::len_t     hdr_len,
  input  roce_tx_pkg::mac_t     hdr_smac,
  input  roce_tx_pkg::mac_t     hdr_dmac,
  input  roce_tx_pkg::ip_t      hdr_sip,
  input  roce_tx_pkg::ip_t      hdr_dip,
  input  logic                  header_taken,
  output roce_tx_pkg::header_t  header
);

  logic [15:0]          ident_q;
  roce_tx_pkg::len_t    ip_total_len;
  roce_tx_pkg::len_t    udp_len;
  logic [19:0]          csum_sum;
  logic [16:0]          csum_fold;
  roce_tx_pkg::csum_t   csum_wrap;
  roce_tx_pkg::csum_t   ip_csum;
  roce_tx_pkg::header_t hdr_msb_first;

  // identification counts frames, one step per header beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ident_q <= '0;
    end else if (header_taken) begin
      ident_q <= ident_q + 16'd1;
    end
  end

  assign ip_total_len = hdr_len + roce_tx_pkg::IP_UDP_OVERHEAD;
  assign udp_len      = hdr_len + roce_tx_pkg::UDP_HDR_BYTES;

  // **************************************************
  // IPv4 header checksum
  // **************************************************
  // ten header words, checksum word counted as zero
  assign csum_sum = 20'({roce_tx_pkg::IP_VER_IHL, 8'h00})
                  + 20'(ip_total_len)
                  + 20'(ident_q)
                  + 20'({roce_tx_pkg::IP_TTL, roce_tx_pkg::IP_PROTO_UDP})
                  + 20'(hdr_sip[31:16]) + 20'(hdr_sip[15:0])
                  + 20'(hdr_dip[31:16]) + 20'(hdr_dip[15:0]);

  // end-around carry, twice covers any overflow of the first fold
  assign csum_fold = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
  assign csum_wrap = csum_fold[15:0] + 16'(csum_fold[16]);
  assign ip_csum   = ~csum_wrap;

  // fields in wire order, first byte in the top bits
  assign hdr_msb_first = {
    hdr_dmac, hdr_smac, roce_tx_pkg::ETHERTYPE_IPV4,
    roce_tx_pkg::IP_VER_IHL, 8'h00, ip_total_len,
    ident_q, 16'h0000,
    roce_tx_pkg::IP_TTL, roce_tx_pkg::IP_PROTO_UDP, ip_csum,
    hdr_sip, hdr_dip,
    roce_tx_pkg::ROCE_UDP_PORT, roce_tx_pkg::ROCE_UDP_PORT,
    udp_len, 16'h0000
  };

  // byte swap so that byte 0 lands in bits 7:0
  always_comb begin
    for (int i = 0; i < roce_tx_pkg::HDR_BYTES; i++) begin
      header[8*i +: 8] = hdr_msb_first[8*(roce_tx_pkg::HDR_BYTES-1-i) +: 8];
    end
  end

endmodule

//--- hdl/frame_beat_if.sv
`timescale 1ns/1ns

// beats from the assembler into the frame FIFO
interface frame_beat_if;

  logic                wr;
  roce_tx_pkg::data_t  data;
  roce_tx_pkg::keep_t  keep;
  logic                last;
  // fewer than the slack entries free
  logic                almost_full;

  modport assembler (
    output wr,
    output data,
    output keep,
    output last,
    input  almost_full
  );

  modport fifo (
    input  wr,
    input  data,
    input  keep,
    input  last,
    output almost_full
  );

endinterface

//--- hdl/roce_tx_pkg.sv
package roce_tx_pkg;

  // **************************************************
  // beat and field widths
  // **************************************************
  localparam int unsigned DATA_W = 256;
  localparam int unsigned KEEP_W = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [KEEP_W-1:0] keep_t;
  typedef logic [47:0]       mac_t;
  typedef logic [31:0]       ip_t;
  typedef logic [15:0]       len_t;
  typedef logic [15:0]       csum_t;

  // byte 0 of the wire sits in bits 7:0
  typedef logic [42*8-1:0]   header_t;

  // **************************************************
  // frame layout
  // **************************************************
  localparam int unsigned HDR_BYTES       = 42;
  localparam int unsigned HDR_CARRY_BYTES = HDR_BYTES - KEEP_W;
  localparam int unsigned FRESH_BYTES     = KEEP_W - HDR_CARRY_BYTES;

  // protocol fields
  localparam len_t          IP_UDP_OVERHEAD = 16'd28;
  localparam len_t          UDP_HDR_BYTES   = 16'd8;
  localparam logic [15:0]   ROCE_UDP_PORT   = 16'd4791;
  localparam logic [7:0]    IP_VER_IHL      = 8'h45;
  localparam logic [7:0]    IP_TTL          = 8'd64;
  localparam logic [7:0]    IP_PROTO_UDP    = 8'd17;
  localparam logic [15:0]   ETHERTYPE_IPV4  = 16'h0800;

  // **************************************************
  // frame FIFO
  // **************************************************
  localparam int unsigned FIFO_DEPTH = 64;
  localparam int unsigned FIFO_SLACK = 2;
  localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);

  typedef logic [FIFO_AW-1:0] fifo_ptr_t;
  typedef logic [FIFO_AW:0]   fifo_cnt_t;

  typedef enum logic [1:0] {
    ASM_IDLE,
    ASM_HEADER,
    ASM_PAYLOAD,
    ASM_TAIL
  } asm_state_e;

endpackage
